// ==== Makefile ====
VERILATOR ?= verilator
TOP       := cpu_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --timescale 1ns/1ps
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps
PASS_TEXT := Verification passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== program.hex ====
// One 32-bit instruction word per line in hex, first word at byte address 0x100
// The @40 line is the word address of that first instruction
@40
80123401 // ADDI r1 = r0 + 0x1234
68F00001 // SW r1 to HEX
940F0F12 // ORI r2 = r1 | 0x0F0F
68F00002
98FFFF23 // XORI r3 = r2 ^ 0xFFFF
68F00003
907F5A34 // ANDI r4 = r3 & 0x7F5A
68F00004
80FFF045 // ADDI r5 = r4 - 16
68F00005
80FFF806 // ADDI r6 = r0 - 8
80000307 // ADDI r7 = r0 + 3
00A00867 // SUB r8 = r6 - r7
68F00008
00B00967 // NAND r9
68F00009
00B40A67 // NOR r10
68F0000A
00B80B65 // NXOR r11 from r6 and r5
68F0000B
00C40C67 // LSHF r12 = r6 << 3
68F0000C
00C00DC1 // RSHF r13 = r12 >>> 20
68F0000D
00240E67 // LT r14
68F0000E
00200F67 // EQ r15
68F0000F
002C0E67 // NE r14
68F0000E
00280F76 // LE r15 = r7 <= r6
68F0000F
68020001 // SW r1 to data word 0x200
48020008 // LW r8 from 0x200
68F02008 // SW r8 to LEDR
48F08009 // LW r9 from KEY
68F02009
800BAD0A // Marker value in r10
8000A10B
8000B20C
8000C30D
8000D40E
20000177 // BEQ r7 r7 taken
68F0000A
20000167 // BEQ r6 r7 not taken
68F0000B
24000167 // BLT r6 r7 taken
68F0000A
24000176 // BLT r7 r6 not taken
68F0000C
28000177 // BLE r7 r7 taken
68F0000A
28000176 // BLE r7 r6 not taken
68F0000D
2C000167 // BNE r6 r7 taken
68F0000A
2C000166 // BNE r6 r6 not taken
68F0000E
30007E0F // At 0x1E8 JAL r15 to 0x1F8
8002AA02 // Return lands here
68F02002 // SW r2 to LEDR
20FFFF00 // Halt loop on itself
68F0000F // Subroutine stores the link to HEX
300000F0 // JAL back through r15
68F0000A

// ==== src/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    typedef logic [31:0] word_t;    // Data word and byte address
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [15:0] imm_t;     // Immediate before sign extension

    // Primary opcodes
    typedef enum logic [5:0] {
        OP1_ALUR = 6'b000000,
        OP1_BEQ  = 6'b001000,
        OP1_BLT  = 6'b001001,
        OP1_BLE  = 6'b001010,
        OP1_BNE  = 6'b001011,
        OP1_JAL  = 6'b001100,
        OP1_LW   = 6'b010010,
        OP1_SW   = 6'b011010,
        OP1_ADDI = 6'b100000,
        OP1_ANDI = 6'b100100,
        OP1_ORI  = 6'b100101,
        OP1_XORI = 6'b100110
    } op1_e;

    // ALUR function codes
    typedef enum logic [7:0] {
        OP2_EQ   = 8'h08,
        OP2_LT   = 8'h09,
        OP2_LE   = 8'h0A,
        OP2_NE   = 8'h0B,
        OP2_ADD  = 8'h20,
        OP2_AND  = 8'h24,
        OP2_OR   = 8'h25,
        OP2_XOR  = 8'h26,
        OP2_SUB  = 8'h28,
        OP2_NAND = 8'h2C,
        OP2_NOR  = 8'h2D,
        OP2_NXOR = 8'h2E,
        OP2_RSHF = 8'h30,
        OP2_LSHF = 8'h31
    } op2_e;

    typedef enum logic [1:0] {
        WB_PC  = 2'd0,  // Link address for JAL
        WB_MEM = 2'd1,
        WB_ALU = 2'd2
    } wb_src_e;

    localparam word_t INST_SIZE = 32'd4;

    // Instruction field positions
    localparam int OP1_HI = 31;
    localparam int OP1_LO = 26;
    localparam int OP2_HI = 25;
    localparam int OP2_LO = 18;
    localparam int IMM_HI = 23;
    localparam int IMM_LO = 8;
    localparam int RD_HI  = 11;
    localparam int RD_LO  = 8;
    localparam int RS_HI  = 7;
    localparam int RS_LO  = 4;
    localparam int RT_HI  = 3;
    localparam int RT_LO  = 0;

endpackage

// ==== src/cpu_map_pkg.sv ====
package cpu_map_pkg;

    typedef logic [23:0] hex_t;
    typedef logic [9:0]  led_t;
    typedef logic [3:0]  key_t;

    localparam cpu_isa_pkg::word_t START_PC = 32'h0000_0100;

    // Memory-mapped I/O
    localparam cpu_isa_pkg::word_t ADDR_HEX  = 32'hFFFF_F000;
    localparam cpu_isa_pkg::word_t ADDR_LEDR = 32'hFFFF_F020;
    localparam cpu_isa_pkg::word_t ADDR_KEY  = 32'hFFFF_F080;

    // Both memories are word arrays indexed by address bits 15..2
    localparam int IMEM_WORDS = 16384;
    localparam int DMEM_WORDS = 16384;
    localparam int MEM_IDX_HI = 15;
    localparam int MEM_IDX_LO = 2;

    localparam hex_t HEX_RESET  = 24'hFEDEAD;
    localparam led_t LEDR_RESET = 10'd0;

endpackage

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic              clk,
    input  logic              reset,
    input  cpu_map_pkg::key_t key,
    output cpu_map_pkg::hex_t hex,
    output cpu_map_pkg::led_t ledr
);

    // Fetch to decode
    cpu_isa_pkg::inst_t    fe_inst;
    cpu_isa_pkg::word_t    fe_pc_next;
    logic                  fe_valid;
    logic                  stall;

    // Decode and register file
    cpu_isa_pkg::reg_idx_t rs;
    cpu_isa_pkg::reg_idx_t rt;
    cpu_isa_pkg::word_t    rs_val;
    cpu_isa_pkg::word_t    rt_val;

    // Decode to execute
    cpu_isa_pkg::op1_e     id_op1;
    cpu_isa_pkg::op2_e     id_op2;
    cpu_isa_pkg::word_t    id_a;
    cpu_isa_pkg::word_t    id_b;
    cpu_isa_pkg::word_t    id_imm;
    cpu_isa_pkg::word_t    id_pc_next;
    cpu_isa_pkg::reg_idx_t id_dst;
    cpu_isa_pkg::wb_src_e  id_wb_src;
    logic                  id_reg_we;
    logic                  id_mem_we;
    logic                  id_mem_re;

    // Execute to memory, plus the redirect back to fetch
    logic                  redirect;
    cpu_isa_pkg::word_t    redirect_pc;
    cpu_isa_pkg::reg_idx_t ex_dst;
    cpu_isa_pkg::word_t    ex_alu;
    cpu_isa_pkg::word_t    ex_store;
    cpu_isa_pkg::word_t    ex_pc_next;
    cpu_isa_pkg::wb_src_e  ex_wb_src;
    logic                  ex_reg_we;
    logic                  ex_mem_we;

    // Writeback
    cpu_isa_pkg::reg_idx_t mem_dst;
    cpu_isa_pkg::reg_idx_t wb_dst;
    logic                  wb_en;
    cpu_isa_pkg::word_t    wb_data;

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .fe_inst(fe_inst), .fe_pc_next(fe_pc_next),
        .fe_valid(fe_valid)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset), .rs(rs), .rt(rt), .wr_idx(wb_dst), .wr_en(wb_en),
        .wr_data(wb_data), .rs_val(rs_val), .rt_val(rt_val)
    );

    decode_unit u_decode (
        .clk(clk), .reset(reset), .fe_inst(fe_inst), .fe_valid(fe_valid),
        .fe_pc_next(fe_pc_next), .redirect(redirect), .ex_dst(ex_dst),
        .mem_dst(mem_dst), .wb_dst(wb_dst), .rs_val(rs_val), .rt_val(rt_val),
        .rs(rs), .rt(rt), .stall(stall), .id_op1(id_op1), .id_op2(id_op2),
        .id_a(id_a), .id_b(id_b), .id_imm(id_imm), .id_pc_next(id_pc_next),
        .id_dst(id_dst), .id_wb_src(id_wb_src), .id_reg_we(id_reg_we),
        .id_mem_we(id_mem_we), .id_mem_re(id_mem_re)
    );

    execute_unit u_execute (
        .clk(clk), .reset(reset), .id_op1(id_op1), .id_op2(id_op2), .id_a(id_a),
        .id_b(id_b), .id_imm(id_imm), .id_pc_next(id_pc_next), .id_dst(id_dst),
        .id_wb_src(id_wb_src), .id_reg_we(id_reg_we), .id_mem_we(id_mem_we),
        .id_mem_re(id_mem_re), .redirect(redirect), .redirect_pc(redirect_pc),
        .ex_dst(ex_dst), .ex_alu(ex_alu), .ex_store(ex_store),
        .ex_pc_next(ex_pc_next), .ex_wb_src(ex_wb_src), .ex_reg_we(ex_reg_we),
        .ex_mem_we(ex_mem_we)
    );

    mem_io_unit u_mem_io (
        .clk(clk), .reset(reset), .ex_dst(ex_dst), .ex_alu(ex_alu),
        .ex_store(ex_store), .ex_pc_next(ex_pc_next), .ex_wb_src(ex_wb_src),
        .ex_reg_we(ex_reg_we), .ex_mem_we(ex_mem_we), .key(key), .mem_dst(mem_dst),
        .wb_dst(wb_dst), .wb_en(wb_en), .wb_data(wb_data), .hex(hex), .ledr(ledr)
    );

endmodule

// ==== src/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_isa_pkg::inst_t    fe_inst,
    input  logic                  fe_valid,
    input  cpu_isa_pkg::word_t    fe_pc_next,
    input  logic                  redirect,
    input  cpu_isa_pkg::reg_idx_t ex_dst,
    input  cpu_isa_pkg::reg_idx_t mem_dst,
    input  cpu_isa_pkg::reg_idx_t wb_dst,
    input  cpu_isa_pkg::word_t    rs_val,
    input  cpu_isa_pkg::word_t    rt_val,
    output cpu_isa_pkg::reg_idx_t rs,
    output cpu_isa_pkg::reg_idx_t rt,
    output logic                  stall,
    output cpu_isa_pkg::op1_e     id_op1,
    output cpu_isa_pkg::op2_e     id_op2,
    output cpu_isa_pkg::word_t    id_a,
    output cpu_isa_pkg::word_t    id_b,
    output cpu_isa_pkg::word_t    id_imm,
    output cpu_isa_pkg::word_t    id_pc_next,
    output cpu_isa_pkg::reg_idx_t id_dst,
    output cpu_isa_pkg::wb_src_e  id_wb_src,
    output logic                  id_reg_we,
    output logic                  id_mem_we,
    output logic                  id_mem_re
);

    cpu_isa_pkg::op1_e     op1;
    cpu_isa_pkg::op2_e     op2;
    cpu_isa_pkg::imm_t     imm;
    cpu_isa_pkg::reg_idx_t rd;
    cpu_isa_pkg::reg_idx_t dst;
    cpu_isa_pkg::wb_src_e  wb_src;
    logic                  reg_we;
    logic                  mem_we;
    logic                  mem_re;
    logic                  use_rt;
    logic                  rs_hit;
    logic                  rt_hit;
    logic                  bubble;

    assign op1 = cpu_isa_pkg::op1_e'(fe_inst[cpu_isa_pkg::OP1_HI:cpu_isa_pkg::OP1_LO]);
    assign op2 = cpu_isa_pkg::op2_e'(fe_inst[cpu_isa_pkg::OP2_HI:cpu_isa_pkg::OP2_LO]);
    assign imm = fe_inst[cpu_isa_pkg::IMM_HI:cpu_isa_pkg::IMM_LO];
    assign rd  = fe_inst[cpu_isa_pkg::RD_HI:cpu_isa_pkg::RD_LO];
    assign rs  = fe_inst[cpu_isa_pkg::RS_HI:cpu_isa_pkg::RS_LO];
    assign rt  = fe_inst[cpu_isa_pkg::RT_HI:cpu_isa_pkg::RT_LO];

    // Control table
    always_comb begin
        reg_we = 1'b0;
        mem_we = 1'b0;
        mem_re = 1'b0;
        use_rt = 1'b0;
        wb_src = cpu_isa_pkg::WB_ALU;
        case (op1)
            cpu_isa_pkg::OP1_ALUR: begin
                reg_we = 1'b1;
                use_rt = 1'b1;
            end
            cpu_isa_pkg::OP1_BEQ, cpu_isa_pkg::OP1_BLT,
            cpu_isa_pkg::OP1_BLE, cpu_isa_pkg::OP1_BNE: use_rt = 1'b1;
            cpu_isa_pkg::OP1_JAL: begin
                reg_we = 1'b1;
                wb_src = cpu_isa_pkg::WB_PC;
            end
            cpu_isa_pkg::OP1_LW: begin
                reg_we = 1'b1;
                mem_re = 1'b1;
                wb_src = cpu_isa_pkg::WB_MEM;
            end
            cpu_isa_pkg::OP1_SW: begin
                mem_we = 1'b1;
                use_rt = 1'b1;
            end
            cpu_isa_pkg::OP1_ADDI, cpu_isa_pkg::OP1_ANDI,
            cpu_isa_pkg::OP1_ORI, cpu_isa_pkg::OP1_XORI: reg_we = 1'b1;
            default: reg_we = 1'b0;
        endcase
        // Fetch bubbles arrive as opcode zero
        if (!fe_valid) begin
            reg_we = 1'b0;
            mem_we = 1'b0;
            mem_re = 1'b0;
        end
    end

    // ALUR writes rd, everything else writes rt
    assign dst = !reg_we ? '0 : (op1 == cpu_isa_pkg::OP1_ALUR) ? rd : rt;

    // id_dst is this unit's copy of the execute-stage destination
    assign rs_hit = (rs != '0) &&
                    (rs == id_dst || rs == ex_dst || rs == mem_dst || rs == wb_dst);
    assign rt_hit = (rt != '0) &&
                    (rt == id_dst || rt == ex_dst || rt == mem_dst || rt == wb_dst);
    assign stall  = fe_valid && (rs_hit || (use_rt && rt_hit));
    assign bubble = stall || redirect;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_op1    <= cpu_isa_pkg::OP1_ALUR;
            id_dst    <= '0;
            id_wb_src <= cpu_isa_pkg::WB_ALU;
            id_reg_we <= 1'b0;
            id_mem_we <= 1'b0;
            id_mem_re <= 1'b0;
        end else begin
            id_op1    <= bubble ? cpu_isa_pkg::OP1_ALUR : op1;
            id_dst    <= bubble ? '0 : dst;
            id_wb_src <= wb_src;
            id_reg_we <= reg_we && !bubble;
            id_mem_we <= mem_we && !bubble;
            id_mem_re <= mem_re && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        id_op2     <= op2;
        id_a       <= rs_val;
        id_b       <= rt_val;
        id_imm     <= {{16{imm[15]}}, imm};   // Sign extend
        id_pc_next <= fe_pc_next;
    end

endmodule

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_isa_pkg::op1_e     id_op1,
    input  cpu_isa_pkg::op2_e     id_op2,
    input  cpu_isa_pkg::word_t    id_a,
    input  cpu_isa_pkg::word_t    id_b,
    input  cpu_isa_pkg::word_t    id_imm,
    input  cpu_isa_pkg::word_t    id_pc_next,
    input  cpu_isa_pkg::reg_idx_t id_dst,
    input  cpu_isa_pkg::wb_src_e  id_wb_src,
    input  logic                  id_reg_we,
    input  logic                  id_mem_we,
    input  logic                  id_mem_re,
    output logic                  redirect,
    output cpu_isa_pkg::word_t    redirect_pc,
    output cpu_isa_pkg::reg_idx_t ex_dst,
    output cpu_isa_pkg::word_t    ex_alu,
    output cpu_isa_pkg::word_t    ex_store,
    output cpu_isa_pkg::word_t    ex_pc_next,
    output cpu_isa_pkg::wb_src_e  ex_wb_src,
    output logic                  ex_reg_we,
    output logic                  ex_mem_we
);

    cpu_isa_pkg::word_t op_b;
    cpu_isa_pkg::word_t alu;
    cpu_isa_pkg::word_t imm_x4;
    logic               is_branch;
    logic               is_jal;
    logic               taken;

    assign is_branch = id_op1 inside {cpu_isa_pkg::OP1_BEQ, cpu_isa_pkg::OP1_BLT,
                                      cpu_isa_pkg::OP1_BLE, cpu_isa_pkg::OP1_BNE};
    assign is_jal    = (id_op1 == cpu_isa_pkg::OP1_JAL);
    assign op_b      = (id_op1 == cpu_isa_pkg::OP1_ALUR || is_branch) ? id_b : id_imm;
    assign imm_x4    = id_imm << 2;

    // Signed compares throughout
    always_comb begin
        case (id_op1)
            cpu_isa_pkg::OP1_BEQ: taken = (id_a == op_b);
            cpu_isa_pkg::OP1_BLT: taken = ($signed(id_a) < $signed(op_b));
            cpu_isa_pkg::OP1_BLE: taken = ($signed(id_a) <= $signed(op_b));
            cpu_isa_pkg::OP1_BNE: taken = (id_a != op_b);
            default:              taken = 1'b0;
        endcase
    end

    assign redirect    = taken || is_jal;
    assign redirect_pc = is_jal ? id_a + imm_x4 : id_pc_next + imm_x4;

    always_comb begin
        if (id_mem_re || id_mem_we) begin
            alu = id_a + op_b;  // Load and store address
        end else begin
            case (id_op1)
                cpu_isa_pkg::OP1_ALUR: begin
                    case (id_op2)
                        cpu_isa_pkg::OP2_EQ:   alu = {31'd0, id_a == op_b};
                        cpu_isa_pkg::OP2_LT:   alu = {31'd0, $signed(id_a) < $signed(op_b)};
                        cpu_isa_pkg::OP2_LE:   alu = {31'd0, $signed(id_a) <= $signed(op_b)};
                        cpu_isa_pkg::OP2_NE:   alu = {31'd0, id_a != op_b};
                        cpu_isa_pkg::OP2_ADD:  alu = id_a + op_b;
                        cpu_isa_pkg::OP2_AND:  alu = id_a & op_b;
                        cpu_isa_pkg::OP2_OR:   alu = id_a | op_b;
                        cpu_isa_pkg::OP2_XOR:  alu = id_a ^ op_b;
                        cpu_isa_pkg::OP2_SUB:  alu = id_a - op_b;
                        cpu_isa_pkg::OP2_NAND: alu = ~(id_a & op_b);
                        cpu_isa_pkg::OP2_NOR:  alu = ~(id_a | op_b);
                        cpu_isa_pkg::OP2_NXOR: alu = ~(id_a ^ op_b);
                        cpu_isa_pkg::OP2_RSHF: alu = $signed(id_a) >>> op_b[4:0];
                        cpu_isa_pkg::OP2_LSHF: alu = id_a << op_b[4:0];
                        default:               alu = '0;
                    endcase
                end
                cpu_isa_pkg::OP1_ADDI: alu = id_a + op_b;
                cpu_isa_pkg::OP1_ANDI: alu = id_a & op_b;
                cpu_isa_pkg::OP1_ORI:  alu = id_a | op_b;
                cpu_isa_pkg::OP1_XORI: alu = id_a ^ op_b;
                default:               alu = '0;
            endcase
        end
    end

    // A taken branch carries no writes and so lands here as a bubble,
    // while JAL keeps its link write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_dst    <= '0;
            ex_wb_src <= cpu_isa_pkg::WB_ALU;
            ex_reg_we <= 1'b0;
            ex_mem_we <= 1'b0;
        end else begin
            ex_dst    <= id_dst;
            ex_wb_src <= id_wb_src;
            ex_reg_we <= id_reg_we;
            ex_mem_we <= id_mem_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu     <= alu;
        ex_store   <= id_b;
        ex_pc_next <= id_pc_next;
    end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    input  logic               redirect,
    input  cpu_isa_pkg::word_t redirect_pc,
    output cpu_isa_pkg::inst_t fe_inst,
    output cpu_isa_pkg::word_t fe_pc_next,
    output logic               fe_valid
);

    cpu_isa_pkg::inst_t imem [cpu_map_pkg::IMEM_WORDS];
    cpu_isa_pkg::word_t pc;
    cpu_isa_pkg::word_t pc_plus;
    cpu_isa_pkg::inst_t inst;

    initial begin
        $readmemh("program.hex", imem);
    end

    // Asynchronous read, the latch below registers it
    assign inst    = imem[pc[cpu_map_pkg::MEM_IDX_HI:cpu_map_pkg::MEM_IDX_LO]];
    assign pc_plus = pc + cpu_isa_pkg::INST_SIZE;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= cpu_map_pkg::START_PC;
            fe_inst    <= '0;
            fe_pc_next <= '0;
            fe_valid   <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            fe_inst  <= '0;     // Zero opcode, decoded as an invalid ALUR
            fe_valid <= 1'b0;
        end else if (!stall) begin
            pc         <= pc_plus;
            fe_inst    <= inst;
            fe_pc_next <= pc_plus;
            fe_valid   <= 1'b1;
        end
    end

endmodule

// ==== src/mem_io_unit.sv ====
`timescale 1ns/1ps

module mem_io_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_isa_pkg::reg_idx_t ex_dst,
    input  cpu_isa_pkg::word_t    ex_alu,
    input  cpu_isa_pkg::word_t    ex_store,
    input  cpu_isa_pkg::word_t    ex_pc_next,
    input  cpu_isa_pkg::wb_src_e  ex_wb_src,
    input  logic                  ex_reg_we,
    input  logic                  ex_mem_we,
    input  cpu_map_pkg::key_t     key,
    output cpu_isa_pkg::reg_idx_t mem_dst,
    output cpu_isa_pkg::reg_idx_t wb_dst,
    output logic                  wb_en,
    output cpu_isa_pkg::word_t    wb_data,
    output cpu_map_pkg::hex_t     hex,
    output cpu_map_pkg::led_t     ledr
);

    cpu_isa_pkg::word_t    dmem [cpu_map_pkg::DMEM_WORDS];
    cpu_isa_pkg::word_t    load_val;
    cpu_isa_pkg::word_t    sel_data;
    cpu_isa_pkg::reg_idx_t wb_dst_q;
    logic                  is_hex;
    logic                  is_ledr;
    logic [cpu_map_pkg::MEM_IDX_HI-cpu_map_pkg::MEM_IDX_LO:0] dmem_idx;

    assign dmem_idx = ex_alu[cpu_map_pkg::MEM_IDX_HI:cpu_map_pkg::MEM_IDX_LO];
    assign is_hex   = (ex_alu == cpu_map_pkg::ADDR_HEX);
    assign is_ledr  = (ex_alu == cpu_map_pkg::ADDR_LEDR);
    assign mem_dst  = ex_reg_we ? ex_dst : '0;

    // Keys are active low on the board
    assign load_val = (ex_alu == cpu_map_pkg::ADDR_KEY) ? {28'd0, ~key} : dmem[dmem_idx];

    always_ff @(posedge clk) begin
        if (ex_mem_we && !is_hex && !is_ledr) begin
            dmem[dmem_idx] <= ex_store;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hex  <= cpu_map_pkg::HEX_RESET;
            ledr <= cpu_map_pkg::LEDR_RESET;
        end else if (ex_mem_we) begin
            if (is_hex) hex <= ex_store[23:0];
            if (is_ledr) ledr <= ex_store[9:0];
        end
    end

    always_comb begin
        case (ex_wb_src)
            cpu_isa_pkg::WB_PC:  sel_data = ex_pc_next;
            cpu_isa_pkg::WB_MEM: sel_data = load_val;
            default:             sel_data = ex_alu;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_en    <= 1'b0;
            wb_dst_q <= '0;
        end else begin
            wb_en    <= ex_reg_we;
            wb_dst_q <= ex_dst;
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= sel_data;
    end

    assign wb_dst = wb_en ? wb_dst_q : '0;

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_isa_pkg::reg_idx_t rs,
    input  cpu_isa_pkg::reg_idx_t rt,
    input  cpu_isa_pkg::reg_idx_t wr_idx,
    input  logic                  wr_en,
    input  cpu_isa_pkg::word_t    wr_data,
    output cpu_isa_pkg::word_t    rs_val,
    output cpu_isa_pkg::word_t    rt_val
);

    cpu_isa_pkg::word_t regs [16];
    logic               wr_live;

    // r0 stays zero
    assign wr_live = wr_en && (wr_idx != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Write-first bypass
    assign rs_val = (wr_live && wr_idx == rs) ? wr_data : regs[rs];
    assign rt_val = (wr_live && wr_idx == rt) ? wr_data : regs[rt];

endmodule

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    typedef enum logic {EV_HEX, EV_LED} ev_kind_e;

    localparam int  WATCH_CYCLES = 200;  // Per expected event
    localparam int  QUIET_CYCLES = 60;
    localparam time DRIVE_DELAY  = 1;

    logic              clk;
    logic              reset;
    cpu_map_pkg::key_t key;
    cpu_map_pkg::hex_t hex;
    cpu_map_pkg::led_t ledr;

    // Expected output changes in program order
    ev_kind_e          exp_kind [$];
    logic [23:0]       exp_val [$];
    bit                table_ready;
    int                next_idx;
    int                check_count;
    int                mismatch_count;
    int                other_count;
    cpu_map_pkg::hex_t prev_hex;
    cpu_map_pkg::led_t prev_led;

    tb_clock_gen u_clk_gen (
        .clk(clk),
        .reset(reset)
    );

    cpu_top u_dut (
        .clk(clk),
        .reset(reset),
        .key(key),
        .hex(hex),
        .ledr(ledr)
    );

    task automatic push_event(input ev_kind_e kind, input logic [23:0] value);
        exp_kind.push_back(kind);
        exp_val.push_back(value);
    endtask

    task automatic build_table();
        // Immediate chain
        push_event(EV_HEX, 24'h001234);
        push_event(EV_HEX, 24'h001F3F);
        push_event(EV_HEX, 24'hFFE0C0);   // XORI with FFFF sign extended
        push_event(EV_HEX, 24'h006040);
        push_event(EV_HEX, 24'h006030);   // 0x6040 minus 16
        // ALUR with r6 = -8 and r7 = 3
        push_event(EV_HEX, 24'hFFFFF5);   // SUB gives -11
        push_event(EV_HEX, 24'hFFFFFF);   // NAND
        push_event(EV_HEX, 24'h000004);   // NOR
        push_event(EV_HEX, 24'h006037);   // NXOR with 0x6030
        push_event(EV_HEX, 24'hFFFFC0);   // LSHF by 3
        push_event(EV_HEX, 24'hFFFFFF);   // RSHF by 20 keeps the sign
        push_event(EV_HEX, 24'h000001);   // LT, signed -8 < 3
        push_event(EV_HEX, 24'h000000);   // EQ
        push_event(EV_HEX, 24'h000001);   // NE
        push_event(EV_HEX, 24'h000000);   // LE, 3 <= -8 false when signed
        // Data memory round trip and KEY
        push_event(EV_LED, 24'h000234);   // Low ten bits of 0x1234
        push_event(EV_LED, 24'h000005);   // KEY 1010 inverted
        // Stores behind the not-taken branches
        push_event(EV_HEX, 24'h0000A1);
        push_event(EV_HEX, 24'h0000B2);
        push_event(EV_HEX, 24'h0000C3);
        push_event(EV_HEX, 24'h0000D4);
        // Link of the JAL at word 58 is 0x100 + 58 * 4 + 4
        push_event(EV_HEX, 24'h0001EC);
        push_event(EV_LED, 24'h0002AA);   // Only after the return
    endtask

    task automatic check_hex(input cpu_map_pkg::hex_t actual,
                             input cpu_map_pkg::hex_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0d ns: %s, hex is %06h, expected %06h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_led(input cpu_map_pkg::led_t actual,
                             input cpu_map_pkg::led_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0d ns: %s, ledr is %03h, expected %03h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_stray(input string port, input logic [23:0] value);
        other_count++;
        if (next_idx < exp_val.size()) begin
            $display("ERROR at %0d ns: %s changed to %0h but event %0d is on the other port",
                     $time, port, value, next_idx);
        end else begin
            $display("ERROR at %0d ns: %s changed to %0h after the last expected event",
                     $time, port, value);
        end
    endtask

    // Called at the falling edge, when both ports are settled
    task automatic watch_ports();
        if (hex !== prev_hex) begin
            if (next_idx < exp_val.size() && exp_kind[next_idx] == EV_HEX) begin
                check_hex(hex, exp_val[next_idx], $sformatf("event %0d", next_idx));
                next_idx++;
            end else begin
                report_stray("hex", hex);
            end
            prev_hex = hex;
        end
        if (ledr !== prev_led) begin
            if (next_idx < exp_val.size() && exp_kind[next_idx] == EV_LED) begin
                check_led(ledr, cpu_map_pkg::led_t'(exp_val[next_idx]),
                          $sformatf("event %0d", next_idx));
                next_idx++;
            end else begin
                report_stray("ledr", {14'd0, ledr});
            end
            prev_led = ledr;
        end
    endtask

    initial begin
        key            = 4'b1111;   // No key pressed
        table_ready    = 1'b0;
        next_idx       = 0;
        check_count    = 0;
        mismatch_count = 0;
        other_count    = 0;
        build_table();
        table_ready = 1'b1;

        @(posedge clk);
        #(DRIVE_DELAY) key = 4'b1010;

        wait (reset == 1'b0);
        @(negedge clk);
        check_hex(hex, 24'hFEDEAD, "value after reset");
        check_led(ledr, 10'd0, "value after reset");
        prev_hex = hex;
        prev_led = ledr;

        while (next_idx < exp_val.size()) begin
            @(negedge clk);
            watch_ports();
        end

        // A skipped marker store would show up here
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            watch_ports();
        end

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready);
        repeat (exp_val.size() * WATCH_CYCLES) @(posedge clk);
        other_count++;
        $display("ERROR at %0d ns: timeout with %0d of %0d expected events seen",
                 $time, next_idx, exp_val.size());
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_count);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== verilog.f ====
src/cpu_isa_pkg.sv
src/cpu_map_pkg.sv
src/fetch_unit.sv
src/reg_file.sv
src/decode_unit.sv
src/execute_unit.sv
src/mem_io_unit.sv
src/cpu_top.sv
tb/tb_clock_gen.sv
tb/cpu_tb.sv
